//--- verilog.f
rtl/rv32i_pkg.sv
rtl/rv32i_regfile.sv
rtl/rv32i_decode.sv
rtl/rv32i_alu.sv
rtl/rv32i_execute.sv
rtl/rv32i_result.sv
rtl/rv32i_core_top.sv
verif/rv32i_core_props.sv
verif/tb_rv32i_core.sv

//--- Bender.yml
package:
  name: rv32i_core

sources:
  - rtl/rv32i_pkg.sv
  - rtl/rv32i_regfile.sv
  - rtl/rv32i_decode.sv
  - rtl/rv32i_alu.sv
  - rtl/rv32i_execute.sv
  - rtl/rv32i_result.sv
  - rtl/rv32i_core_top.sv
  - target: test
    files:
      - verif/rv32i_core_props.sv
      - verif/tb_rv32i_core.sv

//--- verif/tb_rv32i_core.sv
`default_nettype none

module tb_rv32i_core;
  timeunit 1ns;
  timeprecision 1ps;
  import rv32i_pkg::*;

  localparam int PERIOD = 40;
  localparam int RST_CYCLES = 8;
  localparam int DRAIN = 4;
  localparam int N_ALU = 40;
  localparam int N_INSTR = 62 + N_ALU + 13 + 22 + 21 + 6; // Init, alu, fwd, ctrl, mem, stall
  localparam int N_IDLE = 6 + 6 * DRAIN + 5;
  localparam int TIMEOUT_CYCLES = RST_CYCLES + N_INSTR + N_IDLE + 100;
  localparam logic [31:0] SEED = 32'he5a7_0a45;
  localparam logic [17:0] IMM_F3 = {3'd7, 3'd6, 3'd4, 3'd3, 3'd2, 3'd0};
  localparam logic [17:0] CMP_F3 = {3'd7, 3'd6, 3'd5, 3'd4, 3'd1, 3'd0};

  logic      clk = 1'b0;
  logic      rst;
  logic      stall_i;
  logic      instr_valid_i;
  rv32i_word instr_i;
  rv32i_word pc_i;
  redirect_t redirect_o;
  mem_req_t  mem_req_o;
  wb_t       wb_o;

  rv32i_word model_rf [32]; // Architectural state, updated at issue
  wb_t       next_wb;
  redirect_t next_redir;
  mem_req_t  next_mem;
  wb_t       wb_pipe [3];   // Expected outputs in flight
  redirect_t redir_pipe [2];
  mem_req_t  mem_pipe [2];
  rv32i_word fetch_pc;
  string     test_name;
  int        wb_errs = 0;
  int        redir_errs = 0;
  int        mem_errs = 0;

  always #(PERIOD / 2) clk = ~clk;

  rv32i_core_top rv32i_core_top_inst (
    .clk           (clk),
    .rst           (rst),
    .stall_i       (stall_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .redirect_o    (redirect_o),
    .mem_req_o     (mem_req_o),
    .wb_o          (wb_o)
  );

  function automatic rv32i_word r_type(logic [6:0] f7, rv32i_reg_t rs2, rv32i_reg_t rs1,
                                       logic [2:0] f3, rv32i_reg_t rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic rv32i_word i_type(logic [11:0] imm, rv32i_reg_t rs1, logic [2:0] f3,
                                       rv32i_reg_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv32i_word s_type(logic [11:0] imm, rv32i_reg_t rs2, rv32i_reg_t rs1,
                                       logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic rv32i_word b_type(logic [12:0] imm, rv32i_reg_t rs2, rv32i_reg_t rs1,
                                       logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic rv32i_word u_type(logic [19:0] imm, rv32i_reg_t rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic rv32i_word j_type(logic [20:0] imm, rv32i_reg_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic rv32i_word alu_ref(logic [2:0] f3, logic alt, rv32i_word x, rv32i_word y);
    case (f3)
      3'd0:    return alt ? x - y : x + y;
      3'd1:    return x << y[4:0];
      3'd2:    return {31'b0, $signed(x) < $signed(y)};
      3'd3:    return {31'b0, x < y};
      3'd4:    return x ^ y;
      3'd5: begin
        if (alt) begin
          return $unsigned($signed(x) >>> y[4:0]);
        end
        return x >> y[4:0];
      end
      3'd6:    return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_ref(logic [2:0] f3, rv32i_word x, rv32i_word y);
    case (f3)
      3'd0:    return x == y;
      3'd1:    return x != y;
      3'd4:    return $signed(x) < $signed(y);
      3'd5:    return $signed(x) >= $signed(y);
      3'd6:    return x < y;
      3'd7:    return x >= y;
      default: return 1'b0;
    endcase
  endfunction

  task automatic model_step(input rv32i_word ins, input rv32i_word pc_v, output wb_t w,
                            output redirect_t r, output mem_req_t m);
    opcode_t    op;
    rv32i_reg_t rd;
    logic [2:0] f3;
    rv32i_word  a;
    rv32i_word  b;
    rv32i_word  imm_i;
    rv32i_word  imm_s;
    rv32i_word  ea;
    rv32i_word  res;
    logic       wr;
    logic [3:0] be;
    op    = opcode_t'(ins[6:0]);
    rd    = ins[11:7];
    f3    = ins[14:12];
    a     = model_rf[ins[19:15]];
    b     = model_rf[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    w     = '0;
    r     = '0;
    m     = '0;
    wr    = 1'b1;
    res   = '0;
    case (op)
      op_lui:   res = {ins[31:12], 12'b0};
      op_auipc: res = pc_v + {ins[31:12], 12'b0};
      op_jal: begin
        res      = pc_v + 32'd4;
        r.taken  = 1'b1;
        r.target = pc_v + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      op_jalr: begin
        res      = pc_v + 32'd4;
        r.taken  = 1'b1;
        r.target = (a + imm_i) & ~32'h1;
      end
      op_br: begin
        wr       = 1'b0;
        r.taken  = branch_ref(f3, a, b);
        r.target = pc_v + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      op_load, op_store: begin
        wr = 1'b0;
        ea = a + ((op == op_load) ? imm_i : imm_s);
        case (f3[1:0])
          2'b00:   be = 4'b0001;
          2'b01:   be = 4'b0011;
          default: be = 4'b1111;
        endcase
        m.read        = (op == op_load);
        m.write       = (op == op_store);
        m.addr        = {ea[31:2], 2'b00};
        m.addr_offset = ea[1:0];
        m.byte_en     = be << ea[1:0];
        m.wdata       = m.write ? b << (8 * ea[1:0]) : '0;
      end
      op_imm:   res = alu_ref(f3, (f3 == 3'd5) && ins[30], a, imm_i);
      op_reg:   res = alu_ref(f3, ins[30], a, b);
      default:  wr = 1'b0;
    endcase
    w.we   = wr && (rd != '0);
    w.rd   = rd;
    w.data = res;
    if (w.we) begin
      model_rf[rd] = res;
    end
  endtask

  task automatic check_wb(string name, wb_t exp, wb_t act);
    if (act.we !== exp.we || (exp.we && (act.rd !== exp.rd || act.data !== exp.data))) begin
      wb_errs++;
      $display("CHECK FAILED %s: wb expected we=%0b rd=%0d data=%h, actual we=%0b rd=%0d data=%h",
               name, exp.we, exp.rd, exp.data, act.we, act.rd, act.data);
    end
  endtask

  task automatic check_redirect(string name, redirect_t exp, redirect_t act);
    if (act.taken !== exp.taken || (exp.taken && act.target !== exp.target)) begin
      redir_errs++;
      $display("CHECK FAILED %s: redirect expected taken=%0b target=%h, actual taken=%0b target=%h",
               name, exp.taken, exp.target, act.taken, act.target);
    end
  endtask

  task automatic check_mem_req(string name, mem_req_t exp, mem_req_t act);
    logic active;
    active = exp.read || exp.write;
    if (act.read !== exp.read || act.write !== exp.write ||
        (active && (act.addr !== exp.addr || act.byte_en !== exp.byte_en ||
                    act.addr_offset !== exp.addr_offset)) ||
        (exp.write && act.wdata !== exp.wdata)) begin
      mem_errs++;
      $display("CHECK FAILED %s: mem expected r=%0b w=%0b addr=%h be=%b wdata=%h, %s",
               name, exp.read, exp.write, exp.addr, exp.byte_en, exp.wdata,
               $sformatf("actual r=%0b w=%0b addr=%h be=%b wdata=%h",
                         act.read, act.write, act.addr, act.byte_en, act.wdata));
    end
  endtask

  // Expected values advance with the pipeline
  always @(posedge clk) begin
    if (rst) begin
      wb_pipe    <= '{default: '0};
      redir_pipe <= '{default: '0};
      mem_pipe   <= '{default: '0};
    end else if (!stall_i) begin
      wb_pipe[0]    <= next_wb;
      wb_pipe[1]    <= wb_pipe[0];
      wb_pipe[2]    <= wb_pipe[1];
      redir_pipe[0] <= next_redir;
      redir_pipe[1] <= redir_pipe[0];
      mem_pipe[0]   <= next_mem;
      mem_pipe[1]   <= mem_pipe[0];
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      check_wb(test_name, wb_pipe[2], wb_o);
      check_redirect(test_name, redir_pipe[1], redirect_o);
      check_mem_req(test_name, mem_pipe[1], mem_req_o);
    end
  end

  task automatic issue(input rv32i_word ins);
    wb_t       w;
    redirect_t r;
    mem_req_t  m;
    @(negedge clk);
    model_step(ins, fetch_pc, w, r, m);
    stall_i       = 1'b0;
    instr_valid_i = 1'b1;
    instr_i       = ins;
    pc_i          = fetch_pc;
    next_wb       = w;
    next_redir    = r;
    next_mem      = m;
    fetch_pc      = fetch_pc + 32'd4;
  endtask

  task automatic bubble();
    @(negedge clk);
    stall_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = 32'($urandom()); // Ignored while not valid
    next_wb       = '0;
    next_redir    = '0;
    next_mem      = '0;
  endtask

  task automatic stall_for(input int n);
    repeat (n) begin
      @(negedge clk);
      stall_i       = 1'b1;
      instr_valid_i = 1'b0;
    end
  endtask

  task automatic drain();
    repeat (DRAIN) bubble();
  endtask

  function automatic rv32i_word random_alu_instr();
    int          k;
    rv32i_reg_t  rd;
    rv32i_reg_t  s1;
    rv32i_reg_t  s2;
    logic [11:0] imm;
    k   = $urandom_range(0, 20);
    rd  = 5'($urandom_range(1, 31));
    s1  = 5'($urandom());
    s2  = 5'($urandom());
    imm = 12'($urandom());
    if (k < 8) return r_type(7'h00, s2, s1, 3'(k), rd, op_reg);
    if (k == 8) return r_type(7'h20, s2, s1, 3'd0, rd, op_reg); // sub
    if (k == 9) return r_type(7'h20, s2, s1, 3'd5, rd, op_reg); // sra
    if (k < 16) return i_type(imm, s1, IMM_F3[3*(k-10) +: 3], rd, op_imm);
    if (k == 16) return i_type({7'h00, imm[4:0]}, s1, 3'd1, rd, op_imm);
    if (k == 17) return i_type({7'h00, imm[4:0]}, s1, 3'd5, rd, op_imm);
    if (k == 18) return i_type({7'h20, imm[4:0]}, s1, 3'd5, rd, op_imm);
    if (k == 19) return u_type(20'($urandom()), rd, op_lui);
    return u_type(20'($urandom()), rd, op_auipc);
  endfunction

  task automatic reset_and_bubbles();
    test_name = "reset_and_bubbles";
    repeat (6) bubble();
  endtask

  task automatic load_registers();
    test_name = "load_registers";
    for (int r = 1; r < 32; r++) begin
      issue(u_type(20'($urandom()), 5'(r), op_lui));
      issue(i_type(12'($urandom()), 5'(r), 3'd0, 5'(r), op_imm)); // Distance one on rd
    end
    drain();
  endtask

  task automatic alu_results();
    test_name = "alu_results";
    for (int i = 0; i < N_ALU; i++) begin
      issue(random_alu_instr());
    end
    drain();
  endtask

  task automatic forwarding_chains();
    test_name = "forwarding_chains";
    issue(i_type(12'($urandom()), 5'd0, 3'd0, 5'd5, op_imm));
    issue(r_type(7'h00, 5'd5, 5'd5, 3'd0, 5'd6, op_reg));
    issue(r_type(7'h00, 5'd6, 5'd5, 3'd0, 5'd7, op_reg));
    issue(r_type(7'h20, 5'd7, 5'd5, 3'd0, 5'd8, op_reg)); // x5 three back
    issue(r_type(7'h00, 5'd6, 5'd8, 3'd4, 5'd9, op_reg));
    issue(i_type(12'd1, 5'd9, 3'd0, 5'd9, op_imm));
    issue(s_type(12'h010, 5'd9, 5'd0, 3'd2));             // Newer x9 wins over older
    issue(b_type(13'd8, 5'd9, 5'd9, 3'd0));
    issue(i_type(12'd5, 5'd0, 3'd0, 5'd0, op_imm));       // x0 must not forward
    issue(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd11, op_reg));
    issue(j_type(21'd16, 5'd12));
    issue(i_type(12'd0, 5'd12, 3'd0, 5'd13, op_imm));     // Link value forwarded
    issue(s_type(12'h021, 5'd13, 5'd0, 3'd0));
    drain();
  endtask

  task automatic control_transfers();
    logic [12:0] off;
    test_name = "control_transfers";
    issue(i_type(12'hffb, 5'd0, 3'd0, 5'd20, op_imm));    // -5
    issue(i_type(12'd7, 5'd0, 3'd0, 5'd21, op_imm));
    for (int i = 0; i < 6; i++) begin
      off = 13'($urandom()) & 13'h1ffe;
      issue(b_type(off, 5'd21, 5'd20, CMP_F3[3*i +: 3]));
      issue(b_type(off, 5'd20, 5'd21, CMP_F3[3*i +: 3]));
      issue(b_type(off, 5'd20, 5'd20, CMP_F3[3*i +: 3]));
    end
    issue(j_type(21'($urandom()) & 21'h1ffffe, 5'd1));
    issue(i_type(12'($urandom()) & 12'hffe, 5'd21, 3'd0, 5'd2, op_jalr)); // Odd sum
    drain();
  endtask

  task automatic memory_requests();
    logic [11:0] imm;
    logic        legal;
    test_name = "memory_requests";
    issue(u_type(20'($urandom()), 5'd22, op_lui)); // Base with zero low bits
    for (int f = 0; f < 6; f++) begin
      for (int off = 0; off < 4; off++) begin
        case (f % 4)
          0:       legal = 1'b1;
          1:       legal = (off % 2 == 0);
          default: legal = (off == 0);
        endcase
        imm = (12'($urandom()) & 12'hffc) | 12'(off);
        if (f != 3 && legal) begin
          issue(i_type(imm, 5'd22, 3'(f), 5'($urandom_range(1, 31)), op_load));
          if (f < 3) begin
            issue(s_type(imm, 5'($urandom_range(1, 31)), 5'd22, 3'(f)));
          end
        end
      end
    end
    drain();
  endtask

  task automatic stall_pulse();
    test_name = "stall_pulse";
    issue(i_type(12'($urandom()), 5'd0, 3'd0, 5'd23, op_imm));
    issue(r_type(7'h00, 5'd23, 5'd23, 3'd0, 5'd24, op_reg));
    stall_for(3);
    issue(r_type(7'h00, 5'd23, 5'd24, 3'd0, 5'd25, op_reg));
    issue(s_type(12'h00a, 5'd25, 5'd0, 3'd1));
    stall_for(2);
    issue(b_type(13'h020, 5'd25, 5'd25, 3'd0));
    issue(i_type(12'd3, 5'd25, 3'd0, 5'd26, op_imm));
    drain();
  endtask

  initial begin
    #(TIMEOUT_CYCLES * PERIOD);
    $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    rst           = 1'b1;
    stall_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = NOP_INSTR;
    pc_i          = '0;
    next_wb       = '0;
    next_redir    = '0;
    next_mem      = '0;
    fetch_pc      = 32'h0000_1000;
    test_name     = "reset";
    for (int i = 0; i < 32; i++) begin
      model_rf[i] = '0;
    end
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    reset_and_bubbles();
    load_registers();
    alu_results();
    forwarding_chains();
    control_transfers();
    memory_requests();
    stall_pulse();
    @(posedge clk); // Last negedge checks are done
    $display("Summary: %0d writeback, %0d redirect, %0d memory, %0d assertion errors, %0d in total",
             wb_errs, redir_errs, mem_errs, rv32i_core_top_inst.props_inst.fail_count,
             wb_errs + redir_errs + mem_errs + rv32i_core_top_inst.props_inst.fail_count);
    if (wb_errs + redir_errs + mem_errs + rv32i_core_top_inst.props_inst.fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/rv32i_core_props.sv
`default_nettype none

module rv32i_core_props (
  input logic                  clk,
  input logic                  rst,
  input logic                  stall_i,
  input logic                  instr_valid_i,
  input rv32i_pkg::rv32i_word  instr_i,
  input rv32i_pkg::redirect_t  redirect_o,
  input rv32i_pkg::mem_req_t   mem_req_o,
  input rv32i_pkg::wb_t        wb_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import rv32i_pkg::*;

  logic is_xfer;
  int   fail_count = 0; // Read by the testbench summary

  assign is_xfer = instr_valid_i && (instr_i[6:0] == op_br || instr_i[6:0] == op_jal ||
                                     instr_i[6:0] == op_jalr);

  // Issue edge plus two more edges without stall
  redirect_source: assert property (@(posedge clk) disable iff (rst)
    (redirect_o.taken && !$past(stall_i) && !$past(stall_i, 2)) |-> $past(is_xfer, 2))
    else begin
      $error("redirect without a branch or jump two edges earlier");
      fail_count++;
    end

  strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(mem_req_o.read && mem_req_o.write))
    else begin
      $error("memory read and write strobes both high");
      fail_count++;
    end

  idle_byte_en: assert property (@(posedge clk) disable iff (rst)
    !(mem_req_o.read || mem_req_o.write) |-> mem_req_o.byte_en == 4'b0000)
    else begin
      $error("byte enables set without a memory strobe");
      fail_count++;
    end

  no_x0_write: assert property (@(posedge clk) disable iff (rst)
    wb_o.we |-> wb_o.rd != '0)
    else begin
      $error("register write to x0");
      fail_count++;
    end

  // Registers frozen for a stalled edge
  stall_holds: assert property (@(posedge clk) disable iff (rst)
    ($past(stall_i) && !$past(rst)) |->
      ($stable(redirect_o) && $stable(mem_req_o) && $stable(wb_o)))
    else begin
      $error("outputs changed across a stalled edge");
      fail_count++;
    end

endmodule

bind rv32i_core_top rv32i_core_props props_inst (.*);

`default_nettype wire

//--- rtl/rv32i_core_top.sv
`default_nettype none

module rv32i_core_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  stall_i,
  input  logic                  instr_valid_i,
  input  rv32i_pkg::rv32i_word  instr_i,
  input  rv32i_pkg::rv32i_word  pc_i,
  output rv32i_pkg::redirect_t  redirect_o,
  output rv32i_pkg::mem_req_t   mem_req_o,
  output rv32i_pkg::wb_t        wb_o
);
  import rv32i_pkg::*;

  rv32i_reg_t rs1_idx;
  rv32i_reg_t rs2_idx;
  rv32i_word  rs1_data;
  rv32i_word  rs2_data;
  ctrl_word_t id_ex;
  ex_result_t ex_mem;
  wb_t        mem_wb;
  wb_t        rf_wb;

  // Write lands on the first edge without stall
  assign rf_wb.we   = mem_wb.we && !stall_i;
  assign rf_wb.rd   = mem_wb.rd;
  assign rf_wb.data = mem_wb.data;

  rv32i_regfile regfile_inst (
    .clk        (clk),
    .rst        (rst),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_i       (rf_wb)
  );

  rv32i_decode decode_inst (
    .clk           (clk),
    .rst           (rst),
    .stall_i       (stall_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .rs1_idx_o     (rs1_idx),
    .rs2_idx_o     (rs2_idx),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .id_ex_o       (id_ex)
  );

  rv32i_execute execute_inst (
    .clk        (clk),
    .rst        (rst),
    .stall_i    (stall_i),
    .id_ex_i    (id_ex),
    .mem_wb_i   (mem_wb),
    .ex_mem_o   (ex_mem),
    .mem_req_o  (mem_req_o),
    .redirect_o (redirect_o)
  );

  rv32i_result result_inst (
    .clk      (clk),
    .rst      (rst),
    .stall_i  (stall_i),
    .ex_mem_i (ex_mem),
    .wb_o     (mem_wb)
  );

  assign wb_o = mem_wb;

endmodule

`default_nettype wire

//--- rtl/rv32i_result.sv
`default_nettype none

module rv32i_result (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall_i,
  input  rv32i_pkg::ex_result_t  ex_mem_i,
  output rv32i_pkg::wb_t         wb_o
);
  import rv32i_pkg::*;

  wb_t wb_d;
  wb_t mem_wb_q;

  always_comb begin
    wb_d.we   = ex_mem_i.valid && ex_mem_i.rd_we && (ex_mem_i.rd != '0); // Never x0
    wb_d.rd   = ex_mem_i.rd;
    wb_d.data = ex_wb_data(ex_mem_i); // Link or ALU value
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wb_q <= '0;
    end else if (!stall_i) begin
      mem_wb_q <= wb_d;
    end
  end

  assign wb_o = mem_wb_q;

endmodule

`default_nettype wire

//--- rtl/rv32i_execute.sv
`default_nettype none

module rv32i_execute (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall_i,
  input  rv32i_pkg::ctrl_word_t  id_ex_i,
  input  rv32i_pkg::wb_t         mem_wb_i,
  output rv32i_pkg::ex_result_t  ex_mem_o,
  output rv32i_pkg::mem_req_t    mem_req_o,
  output rv32i_pkg::redirect_t   redirect_o
);
  import rv32i_pkg::*;

  ex_result_t ex_mem_d;
  ex_result_t ex_mem_q;
  mem_req_t   mem_req_d;
  mem_req_t   mem_req_q;
  redirect_t  redirect_d;
  redirect_t  redirect_q;
  rv32i_word  ex_fwd_data;
  rv32i_word  rs1_fwd;
  rv32i_word  rs2_fwd;
  rv32i_word  alu_a;
  rv32i_word  alu_b;
  rv32i_word  alu_f;
  logic       br_en;
  logic       is_load;
  logic       is_store;
  logic [3:0] be_base;

  // Youngest producer wins
  function automatic rv32i_word fwd_operand(rv32i_reg_t idx, rv32i_word id_data,
                                            ex_result_t ex_mem, rv32i_word ex_data,
                                            wb_t mem_wb);
    if (ex_mem.valid && ex_mem.rd_we && ex_mem.rd == idx && idx != '0) begin
      return ex_data;
    end else if (mem_wb.we && mem_wb.rd == idx && idx != '0) begin
      return mem_wb.data;
    end
    return id_data;
  endfunction

  assign ex_fwd_data = ex_wb_data(ex_mem_q);
  assign is_load     = id_ex_i.valid && (id_ex_i.opcode == op_load);
  assign is_store    = id_ex_i.valid && (id_ex_i.opcode == op_store);

  always_comb begin
    rs1_fwd = fwd_operand(id_ex_i.rs1, id_ex_i.rs1_data, ex_mem_q, ex_fwd_data, mem_wb_i);
    rs2_fwd = fwd_operand(id_ex_i.rs2, id_ex_i.rs2_data, ex_mem_q, ex_fwd_data, mem_wb_i);
    case (id_ex_i.src_a)
      src_a_pc:   alu_a = id_ex_i.pc;
      src_a_zero: alu_a = '0;
      default:    alu_a = rs1_fwd;
    endcase
    alu_b = (id_ex_i.src_b == src_b_imm) ? id_ex_i.imm : rs2_fwd;
  end

  rv32i_alu alu_inst (
    .aluop_i (id_ex_i.aluop),
    .a_i     (alu_a),
    .b_i     (alu_b),
    .cmpop_i (id_ex_i.cmpop),
    .cmp_a_i (rs1_fwd),
    .cmp_b_i (rs2_fwd),
    .f_o     (alu_f),
    .br_en_o (br_en)
  );

  always_comb begin
    ex_mem_d.valid   = id_ex_i.valid;
    ex_mem_d.opcode  = id_ex_i.opcode;
    ex_mem_d.rd      = id_ex_i.rd;
    ex_mem_d.rd_we   = id_ex_i.rd_we;
    ex_mem_d.pc      = id_ex_i.pc;
    ex_mem_d.alu_out = alu_f;
    ex_mem_d.br_en   = br_en && (id_ex_i.opcode == op_br);

    redirect_d.taken = id_ex_i.valid &&
                       ((id_ex_i.opcode == op_br && br_en) ||
                        id_ex_i.opcode == op_jal || id_ex_i.opcode == op_jalr);
    redirect_d.target = '0;
    if (redirect_d.taken) begin
      redirect_d.target = (id_ex_i.opcode == op_jalr) ? {alu_f[XLEN-1:1], 1'b0} : alu_f;
    end
  end

  always_comb begin
    case (mem_funct3_t'(id_ex_i.funct3))
      lw:       be_base = 4'b1111;
      lh, lhu:  be_base = 4'b0011;
      default:  be_base = 4'b0001;
    endcase
    mem_req_d = '0;
    if (is_load || is_store) begin
      mem_req_d.read        = is_load;
      mem_req_d.write       = is_store;
      mem_req_d.addr        = {alu_f[XLEN-1:2], 2'b00};
      mem_req_d.addr_offset = alu_f[1:0];
      mem_req_d.byte_en     = be_base << alu_f[1:0];
      if (is_store) begin
        mem_req_d.wdata = rs2_fwd << {alu_f[1:0], 3'b000}; // Into byte lanes
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem_q   <= '0;
      mem_req_q  <= '0;
      redirect_q <= '0;
    end else if (!stall_i) begin
      ex_mem_q   <= ex_mem_d;
      mem_req_q  <= mem_req_d;
      redirect_q <= redirect_d;
    end
  end

  assign ex_mem_o   = ex_mem_q;
  assign mem_req_o  = mem_req_q;
  assign redirect_o = redirect_q;

endmodule

`default_nettype wire

//--- rtl/rv32i_alu.sv
`default_nettype none

module rv32i_alu (
  input  rv32i_pkg::alu_op_t   aluop_i,
  input  rv32i_pkg::rv32i_word a_i,
  input  rv32i_pkg::rv32i_word b_i,
  input  rv32i_pkg::cmp_op_t   cmpop_i,
  input  rv32i_pkg::rv32i_word cmp_a_i,
  input  rv32i_pkg::rv32i_word cmp_b_i,
  output rv32i_pkg::rv32i_word f_o,
  output logic                 br_en_o
);
  import rv32i_pkg::*;

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (aluop_i)
      alu_add:    f_o = a_i + b_i;
      alu_sub:    f_o = a_i - b_i;
      alu_sll:    f_o = a_i << shamt;
      alu_slt:    f_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
      alu_sltu:   f_o = {{(XLEN-1){1'b0}}, a_i < b_i};
      alu_xor:    f_o = a_i ^ b_i;
      alu_srl:    f_o = a_i >> shamt;
      alu_sra:    f_o = $unsigned($signed(a_i) >>> shamt);
      alu_or:     f_o = a_i | b_i;
      alu_and:    f_o = a_i & b_i;
      alu_pass_b: f_o = b_i; // lui
      default:    f_o = '0;
    endcase
  end

  // Comparator works on register operands, never on the immediate
  always_comb begin
    case (cmpop_i)
      beq:     br_en_o = (cmp_a_i == cmp_b_i);
      bne:     br_en_o = (cmp_a_i != cmp_b_i);
      blt:     br_en_o = ($signed(cmp_a_i) < $signed(cmp_b_i));
      bge:     br_en_o = ($signed(cmp_a_i) >= $signed(cmp_b_i));
      bltu:    br_en_o = (cmp_a_i < cmp_b_i);
      bgeu:    br_en_o = (cmp_a_i >= cmp_b_i);
      default: br_en_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/rv32i_decode.sv
`default_nettype none

module rv32i_decode (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall_i,
  input  logic                   instr_valid_i,
  input  rv32i_pkg::rv32i_word   instr_i,
  input  rv32i_pkg::rv32i_word   pc_i,
  output rv32i_pkg::rv32i_reg_t  rs1_idx_o,
  output rv32i_pkg::rv32i_reg_t  rs2_idx_o,
  input  rv32i_pkg::rv32i_word   rs1_data_i,
  input  rv32i_pkg::rv32i_word   rs2_data_i,
  output rv32i_pkg::ctrl_word_t  id_ex_o
);
  import rv32i_pkg::*;

  rv32i_word  instr;
  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rv32i_word  imm_i;
  rv32i_word  imm_s;
  rv32i_word  imm_b;
  rv32i_word  imm_u;
  rv32i_word  imm_j;
  logic       supported;
  ctrl_word_t ctrl;
  ctrl_word_t id_ex_q;

  function automatic alu_op_t alu_from_funct3(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign instr  = instr_valid_i ? instr_i : NOP_INSTR; // Empty slot decodes as a nop
  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  assign rs1_idx_o = instr[19:15];
  assign rs2_idx_o = instr[24:20];

  always_comb begin
    ctrl          = '0;
    ctrl.funct3   = funct3;
    ctrl.cmpop    = cmp_op_t'(funct3);
    ctrl.rd       = instr[11:7];
    ctrl.rs1      = instr[19:15];
    ctrl.rs2      = instr[24:20];
    ctrl.pc       = pc_i;
    ctrl.rs1_data = rs1_data_i;
    ctrl.rs2_data = rs2_data_i;
    supported     = 1'b1;
    case (opcode)
      op_lui: begin
        ctrl.aluop = alu_pass_b;
        ctrl.src_a = src_a_zero;
        ctrl.src_b = src_b_imm;
        ctrl.imm   = imm_u;
        ctrl.rd_we = 1'b1;
      end
      op_auipc, op_jal: begin
        ctrl.src_a = src_a_pc; // Sum is pc+imm
        ctrl.src_b = src_b_imm;
        ctrl.imm   = (opcode == op_jal) ? imm_j : imm_u;
        ctrl.rd_we = 1'b1;
      end
      op_jalr: begin
        ctrl.src_b = src_b_imm;
        ctrl.imm   = imm_i;
        ctrl.rd_we = 1'b1;
        supported  = (funct3 == 3'b000);
      end
      op_br: begin
        ctrl.src_a = src_a_pc; // ALU builds the target
        ctrl.src_b = src_b_imm;
        ctrl.imm   = imm_b;
        supported  = (funct3[2:1] != 2'b01);
      end
      op_load: begin
        ctrl.src_b = src_b_imm;
        ctrl.imm   = imm_i;
        supported  = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
      end
      op_store: begin
        ctrl.src_b = src_b_imm;
        ctrl.imm   = imm_s;
        supported  = (funct3[2] == 1'b0) && (funct3 != 3'b011);
      end
      op_imm: begin
        ctrl.aluop = alu_from_funct3(funct3, (funct3 == 3'b101) && funct7[5]);
        ctrl.src_b = src_b_imm;
        ctrl.imm   = imm_i;
        ctrl.rd_we = 1'b1;
        if (funct3 == 3'b001) begin
          supported = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
          supported = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end
      end
      op_reg: begin
        ctrl.aluop = alu_from_funct3(funct3, funct7[5]);
        ctrl.rd_we = 1'b1;
        supported  = (funct7 == 7'b0000000) ||
                     ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      default: supported = 1'b0;
    endcase
    ctrl.opcode = opcode;
    ctrl.valid  = instr_valid_i && supported;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      id_ex_q <= '0;
    end else if (!stall_i) begin
      id_ex_q <= ctrl.valid ? ctrl : '0; // Bubble is all zero
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

//--- rtl/rv32i_regfile.sv
`default_nettype none

module rv32i_regfile (
  input  logic                   clk,
  input  logic                   rst,
  input  rv32i_pkg::rv32i_reg_t  rs1_idx_i,
  input  rv32i_pkg::rv32i_reg_t  rs2_idx_i,
  output rv32i_pkg::rv32i_word   rs1_data_o,
  output rv32i_pkg::rv32i_word   rs2_data_o,
  input  rv32i_pkg::wb_t         wb_i
);
  import rv32i_pkg::*;

  rv32i_word regs [31:1]; // x0 has no storage

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.we && wb_i.rd != '0) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // Same-cycle write is visible to the reader
  assign rs1_data_o = (rs1_idx_i == '0) ? '0 :
                      (wb_i.we && wb_i.rd == rs1_idx_i) ? wb_i.data :
                      regs[rs1_idx_i];

  assign rs2_data_o = (rs2_idx_i == '0) ? '0 :
                      (wb_i.we && wb_i.rd == rs2_idx_i) ? wb_i.data :
                      regs[rs2_idx_i];

endmodule

`default_nettype wire

//--- rtl/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

  localparam int XLEN = 32;
  localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0,x0,0

  typedef logic [XLEN-1:0] rv32i_word;
  typedef logic [4:0] rv32i_reg_t;

  typedef enum logic [6:0] {
    op_none  = 7'b0000000, // Bubble or unsupported
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_t;

  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } cmp_op_t;

  typedef enum logic [2:0] {
    lb  = 3'b000, // Also sb
    lh  = 3'b001, // Also sh
    lw  = 3'b010, // Also sw
    lbu = 3'b100,
    lhu = 3'b101
  } mem_funct3_t;

  typedef enum logic [1:0] {
    src_a_rs1,
    src_a_pc,
    src_a_zero
  } alu_src_a_t;

  typedef enum logic {
    src_b_rs2,
    src_b_imm
  } alu_src_b_t;

  typedef struct packed {
    logic       valid;
    opcode_t    opcode;
    alu_op_t    aluop;
    cmp_op_t    cmpop;
    logic [2:0] funct3;
    rv32i_reg_t rd;
    rv32i_reg_t rs1;
    rv32i_reg_t rs2;
    logic       rd_we;
    alu_src_a_t src_a;
    alu_src_b_t src_b;
    rv32i_word  pc;
    rv32i_word  imm;
    rv32i_word  rs1_data;
    rv32i_word  rs2_data;
  } ctrl_word_t;

  typedef struct packed {
    logic       valid;
    opcode_t    opcode;
    rv32i_reg_t rd;
    logic       rd_we;
    rv32i_word  pc;
    rv32i_word  alu_out;
    logic       br_en;
  } ex_result_t;

  typedef struct packed {
    logic       read;
    logic       write;
    rv32i_word  addr;        // Word aligned
    rv32i_word  wdata;       // Already in its byte lanes
    logic [3:0] byte_en;
    logic [1:0] addr_offset;
  } mem_req_t;

  typedef struct packed {
    logic      taken;
    rv32i_word target;
  } redirect_t;

  typedef struct packed {
    logic       we;
    rv32i_reg_t rd;
    rv32i_word  data;
  } wb_t;

  // Value an execute result will write back, also used for forwarding
  function automatic rv32i_word ex_wb_data(ex_result_t r);
    case (r.opcode)
      op_jal, op_jalr: return r.pc + 32'd4; // Link address
      default:         return r.alu_out;    // lui and auipc come through the ALU
    endcase
  endfunction

endpackage

`default_nettype wire
